// ==== src/fast_pkg.sv ====
`default_nettype none

package fast_pkg;

    // radius of the Bresenham circle and the half size of the window
    localparam int WIN_RADIUS = 3;

    // contiguous pixels needed for a corner
    localparam int ARC_LEN = 9;

    typedef logic [7:0] pixel_t;

    typedef logic [9:0] coord_t;

    // ring[0] sits three rows above the center, then clockwise
    typedef struct packed {
        pixel_t        center;
        pixel_t [15:0] ring;
    } fast_circle_t;

    typedef struct packed {
        logic       flag;
        logic [7:0] score;
    } corner_t;

    typedef struct packed {
        coord_t  x;
        coord_t  y;
        corner_t corner;
    } point_t;

endpackage

`default_nettype wire

// ==== src/fast_frame_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module fast_frame_ctrl import fast_pkg::*; #(
    parameter int IMG_WIDTH  = 32,
    parameter int IMG_HEIGHT = 24
) (
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_valid,
    input  logic   i_start,
    output logic   o_ready,
    output logic   o_start,
    output logic   o_end,
    output logic   o_coord_valid,
    output coord_t o_coord_x,
    output coord_t o_coord_y
);

    localparam int FILL_BEATS = WIN_RADIUS * IMG_WIDTH + WIN_RADIUS;
    localparam int CNT_W      = $clog2(FILL_BEATS + 3);
    localparam coord_t X_LAST = coord_t'(IMG_WIDTH - 1);
    localparam coord_t Y_LAST = coord_t'(IMG_HEIGHT - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FILL,
        S_WORK
    } state_e;

    state_e           state;
    logic [CNT_W-1:0] beat_cnt;
    logic             last_px;

    assign last_px       = (o_coord_x == X_LAST) && (o_coord_y == Y_LAST);
    assign o_coord_valid = (state == S_WORK);
    // idle, but not in the cycle that carries the last point
    assign o_ready       = (state == S_IDLE) && !o_end;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= S_IDLE;
            beat_cnt  <= '0;
            o_coord_x <= '0;
            o_coord_y <= '0;
        end else if (i_valid) begin
            case (state)
                S_IDLE: begin
                    if (i_start && o_ready) begin
                        state    <= S_FILL;
                        beat_cnt <= CNT_W'(1);
                    end
                end
                S_FILL: begin
                    // window fill plus the two segment test stages
                    if (beat_cnt == CNT_W'(FILL_BEATS + 2)) begin
                        state     <= S_WORK;
                        o_coord_x <= '0;
                        o_coord_y <= '0;
                    end else begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                end
                S_WORK: begin
                    if (last_px) begin
                        state     <= S_IDLE;
                        o_coord_x <= '0;
                        o_coord_y <= '0;
                    end else if (o_coord_x == X_LAST) begin
                        o_coord_x <= '0;
                        o_coord_y <= o_coord_y + 1'b1;
                    end else begin
                        o_coord_x <= o_coord_x + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // pulses line up with the registered point in the border stage
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_start <= 1'b0;
            o_end   <= 1'b0;
        end else begin
            o_start <= i_valid && o_coord_valid && (o_coord_x == '0) && (o_coord_y == '0);
            o_end   <= i_valid && o_coord_valid && last_px;
        end
    end

    // work starts at the origin, never straight out of idle
    a_work_after_fill: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_coord_valid) |-> $past(!o_ready) && (o_coord_x == '0) && (o_coord_y == '0))
        else $error("coordinates started outside a frame");

    a_coord_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_coord_valid |-> (o_coord_x <= X_LAST) && (o_coord_y <= Y_LAST))
        else $error("coordinate outside the image");

    a_ready_after_end: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_end |=> o_ready)
        else $error("not ready after end of frame");

endmodule

`default_nettype wire

// ==== src/fast_window.sv ====
`timescale 1ns/100ps
`default_nettype none

module fast_window import fast_pkg::*; #(
    parameter int IMG_WIDTH = 32
) (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_valid,
    input  pixel_t       i_pixel,
    output fast_circle_t o_circle
);

    localparam int WIN  = 2 * WIN_RADIUS + 1;
    localparam int NDLY = 2 * WIN_RADIUS;
    localparam int R    = WIN_RADIUS;

    // one image row per delay, chained
    pixel_t row_dly [NDLY][IMG_WIDTH];

    // col_in[j] is the pixel j rows above the incoming one
    pixel_t col_in [WIN];

    // win[0] is the oldest row, column WIN-1 the newest pixel
    pixel_t win [WIN][WIN];

    always_comb begin
        col_in[0] = i_pixel;
        for (int j = 1; j < WIN; j++) begin
            col_in[j] = row_dly[j-1][IMG_WIDTH-1];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            for (int k = 0; k < NDLY; k++) begin
                row_dly[k][0] <= col_in[k];
                for (int i = 1; i < IMG_WIDTH; i++) begin
                    row_dly[k][i] <= row_dly[k][i-1];
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int r = 0; r < WIN; r++) begin
                for (int c = 0; c < WIN; c++) begin
                    win[r][c] <= '0;
                end
            end
        end else if (i_valid) begin
            for (int r = 0; r < WIN; r++) begin
                for (int c = 0; c < WIN - 1; c++) begin
                    win[r][c] <= win[r][c+1];
                end
                win[r][WIN-1] <= col_in[WIN-1-r];
            end
        end
    end

    // radius 3 taps, clockwise from the top
    always_comb begin
        o_circle.center   = win[R][R];
        o_circle.ring[0]  = win[R-3][R];
        o_circle.ring[1]  = win[R-3][R+1];
        o_circle.ring[2]  = win[R-2][R+2];
        o_circle.ring[3]  = win[R-1][R+3];
        o_circle.ring[4]  = win[R][R+3];
        o_circle.ring[5]  = win[R+1][R+3];
        o_circle.ring[6]  = win[R+2][R+2];
        o_circle.ring[7]  = win[R+3][R+1];
        o_circle.ring[8]  = win[R+3][R];
        o_circle.ring[9]  = win[R+3][R-1];
        o_circle.ring[10] = win[R+2][R-2];
        o_circle.ring[11] = win[R+1][R-3];
        o_circle.ring[12] = win[R][R-3];
        o_circle.ring[13] = win[R-1][R-3];
        o_circle.ring[14] = win[R-2][R-2];
        o_circle.ring[15] = win[R-3][R-1];
    end

endmodule

`default_nettype wire

// ==== src/fast_segment_test.sv ====
`timescale 1ns/100ps
`default_nettype none

module fast_segment_test import fast_pkg::*; #(
    parameter int THRESHOLD = 20
) (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_valid,
    input  fast_circle_t i_circle,
    output corner_t      o_corner
);

    localparam logic [8:0] THR = 9'(THRESHOLD);

    logic [15:0] bright_c;
    logic [15:0] dark_c;
    logic [11:0] acc_b;
    logic [11:0] acc_d;
    logic [7:0]  sum_b_c;
    logic [7:0]  sum_d_c;

    logic [15:0] bright_q;
    logic [15:0] dark_q;
    logic [7:0]  sum_b_q;
    logic [7:0]  sum_d_q;

    logic        arc_hit;
    corner_t     corner_c;

    // hi - lo - THRESHOLD, only called when the result is positive
    function automatic logic [7:0] excess(input pixel_t hi, input pixel_t lo);
        logic [8:0] d;
        d = {1'b0, hi} - {1'b0, lo} - THR;
        return d[7:0];
    endfunction

    // any run of ARC_LEN set bits, wrapping around the ring
    function automatic logic has_arc(input logic [15:0] m);
        logic [31:0] dbl;
        logic        hit;
        dbl = {m, m};
        hit = 1'b0;
        for (int s = 0; s < 16; s++) begin
            hit = hit | (&dbl[s +: ARC_LEN]);
        end
        return hit;
    endfunction

    // stage 1 classify and sum
    always_comb begin
        acc_b = '0;
        acc_d = '0;
        for (int i = 0; i < 16; i++) begin
            bright_c[i] = {1'b0, i_circle.ring[i]} > ({1'b0, i_circle.center} + THR);
            dark_c[i]   = ({1'b0, i_circle.ring[i]} + THR) < {1'b0, i_circle.center};
            if (bright_c[i]) begin
                acc_b = acc_b + 12'(excess(i_circle.ring[i], i_circle.center));
            end
            if (dark_c[i]) begin
                acc_d = acc_d + 12'(excess(i_circle.center, i_circle.ring[i]));
            end
        end
        sum_b_c = (acc_b > 12'd255) ? 8'hff : acc_b[7:0];
        sum_d_c = (acc_d > 12'd255) ? 8'hff : acc_d[7:0];
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bright_q <= '0;
            dark_q   <= '0;
            sum_b_q  <= '0;
            sum_d_q  <= '0;
        end else if (i_valid) begin
            bright_q <= bright_c;
            dark_q   <= dark_c;
            sum_b_q  <= sum_b_c;
            sum_d_q  <= sum_d_c;
        end
    end

    // stage 2 arc search and score pick
    always_comb begin
        arc_hit        = has_arc(bright_q) || has_arc(dark_q);
        corner_c.flag  = arc_hit;
        corner_c.score = '0;
        if (arc_hit) begin
            corner_c.score = (sum_b_q > sum_d_q) ? sum_b_q : sum_d_q;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_corner <= '0;
        end else if (i_valid) begin
            o_corner <= corner_c;
        end
    end

    // each pixel of the arc adds at least one to its sum
    a_score_matches_flag: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_corner.flag ? (o_corner.score >= 8'(ARC_LEN)) : (o_corner.score == '0))
        else $error("score does not match the corner flag");

endmodule

`default_nettype wire

// ==== src/fast_border_mask.sv ====
`timescale 1ns/100ps
`default_nettype none

module fast_border_mask import fast_pkg::*; #(
    parameter int IMG_WIDTH  = 32,
    parameter int IMG_HEIGHT = 24,
    parameter int EDGE       = 4
) (
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_valid,
    input  logic    i_coord_valid,
    input  coord_t  i_coord_x,
    input  coord_t  i_coord_y,
    input  corner_t i_corner,
    output point_t  o_point,
    output logic    o_point_valid
);

    localparam coord_t X_LO = coord_t'(EDGE);
    localparam coord_t Y_LO = coord_t'(EDGE);
    localparam coord_t X_HI = coord_t'(IMG_WIDTH - 1 - EDGE);
    localparam coord_t Y_HI = coord_t'(IMG_HEIGHT - 1 - EDGE);

    // wrapped windows must stay inside the border
    if (EDGE < WIN_RADIUS) begin : g_edge_check
        $error("EDGE must be at least WIN_RADIUS");
    end

    logic   masked;
    point_t point_c;

    always_comb begin
        masked = (i_coord_x < X_LO) || (i_coord_x > X_HI) ||
                 (i_coord_y < Y_LO) || (i_coord_y > Y_HI);
        point_c.x      = i_coord_x;
        point_c.y      = i_coord_y;
        point_c.corner = masked ? '0 : i_corner;
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_point <= point_c;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_point_valid <= 1'b0;
        end else begin
            o_point_valid <= i_valid && i_coord_valid;
        end
    end

    // a valid point carries the coordinates of the beat before it
    a_valid_after_beat: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_point_valid |-> $past(i_valid) && (o_point.x == $past(i_coord_x))
            && (o_point.y == $past(i_coord_y)))
        else $error("point valid without a fresh point");

endmodule

`default_nettype wire

// ==== src/fast_detector.sv ====
`timescale 1ns/100ps
`default_nettype none

module fast_detector import fast_pkg::*; #(
    parameter int IMG_WIDTH  = 32,
    parameter int IMG_HEIGHT = 24,
    parameter int EDGE       = 4,
    parameter int THRESHOLD  = 20
) (
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_valid,
    input  logic   i_start,
    input  pixel_t i_pixel,
    output logic   o_ready,
    output logic   o_start,
    output logic   o_end,
    output logic   o_point_valid,
    output point_t o_point
);

    fast_circle_t circle;
    corner_t      corner;
    coord_t       coord_x;
    coord_t       coord_y;
    logic         coord_valid;

    fast_frame_ctrl #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) i_fast_frame_ctrl (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_valid       (i_valid),
        .i_start       (i_start),
        .o_ready       (o_ready),
        .o_start       (o_start),
        .o_end         (o_end),
        .o_coord_valid (coord_valid),
        .o_coord_x     (coord_x),
        .o_coord_y     (coord_y)
    );

    fast_window #(
        .IMG_WIDTH (IMG_WIDTH)
    ) i_fast_window (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (i_valid),
        .i_pixel  (i_pixel),
        .o_circle (circle)
    );

    fast_segment_test #(
        .THRESHOLD (THRESHOLD)
    ) i_fast_segment_test (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (i_valid),
        .i_circle (circle),
        .o_corner (corner)
    );

    fast_border_mask #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT),
        .EDGE       (EDGE)
    ) i_fast_border_mask (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_valid       (i_valid),
        .i_coord_valid (coord_valid),
        .i_coord_x     (coord_x),
        .i_coord_y     (coord_y),
        .i_corner      (corner),
        .o_point       (o_point),
        .o_point_valid (o_point_valid)
    );

endmodule

`default_nettype wire

// ==== sim/tb_fast_detector.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_fast_detector import fast_pkg::*;;

    localparam int IMG_WIDTH  = 32;
    localparam int IMG_HEIGHT = 24;
    localparam int EDGE       = 4;
    localparam int THRESHOLD  = 20;
    localparam int NPIX       = IMG_WIDTH * IMG_HEIGHT;
    localparam int FILL_BEATS = 3 * IMG_WIDTH + 3;
    localparam int TIMEOUT    = 2 * (NPIX + FILL_BEATS + 8) * 2 + 200;
    localparam int ARC        = 9;
    localparam int BASE       = 110;

    // radius 3 circle, clockwise from the pixel above the center
    localparam int RING_DX [16] = '{0, 1, 2, 3, 3, 3, 2, 1, 0, -1, -2, -3, -3, -3, -2, -1};
    localparam int RING_DY [16] = '{-3, -3, -2, -1, 0, 1, 2, 3, 3, 3, 2, 1, 0, -1, -2, -3};

    logic   i_clk;
    logic   i_rst_n;
    logic   i_valid;
    logic   i_start;
    pixel_t i_pixel;
    logic   o_ready;
    logic   o_start;
    logic   o_end;
    logic   o_point_valid;
    point_t o_point;

    logic [7:0] img [IMG_HEIGHT][IMG_WIDTH];
    int         point_idx;
    int         corner_cnt;
    logic       end_seen;
    int         err_cnt;
    int         check_cnt;
    int         cycle_cnt;

    fast_detector #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT),
        .EDGE       (EDGE),
        .THRESHOLD  (THRESHOLD)
    ) i_fast_detector (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_valid       (i_valid),
        .i_start       (i_start),
        .i_pixel       (i_pixel),
        .o_ready       (o_ready),
        .o_start       (o_start),
        .o_end         (o_end),
        .o_point_valid (o_point_valid),
        .o_point       (o_point)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("timeout: no end of frame after %0d cycles", cycle_cnt);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic check_field(input string name, input int exp_val, input int act_val);
        check_cnt++;
        assert (exp_val == act_val) else begin
            $display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp_val, act_val);
            err_cnt++;
        end
    endtask

    // flag and score straight from the segment test rules
    function automatic corner_t expected_corner(input int x, input int y);
        int          c;
        int          p;
        int          sum_b;
        int          sum_d;
        int          best;
        logic [15:0] bright;
        logic [15:0] dark;
        logic        run_b;
        logic        run_d;
        logic        flag;
        corner_t     res;
        res   = '0;
        flag  = 1'b0;
        sum_b = 0;
        sum_d = 0;
        if (x < EDGE || x > IMG_WIDTH - 1 - EDGE || y < EDGE || y > IMG_HEIGHT - 1 - EDGE) begin
            return res;
        end
        c = int'(img[y][x]);
        for (int i = 0; i < 16; i++) begin
            p         = int'(img[y + RING_DY[i]][x + RING_DX[i]]);
            bright[i] = (p > c + THRESHOLD);
            dark[i]   = (p < c - THRESHOLD);
            if (bright[i]) begin
                sum_b += p - c - THRESHOLD;
            end
            if (dark[i]) begin
                sum_d += c - p - THRESHOLD;
            end
        end
        for (int s = 0; s < 16; s++) begin
            run_b = 1'b1;
            run_d = 1'b1;
            for (int k = 0; k < ARC; k++) begin
                run_b &= bright[(s + k) % 16];
                run_d &= dark[(s + k) % 16];
            end
            flag |= run_b | run_d;
        end
        if (flag) begin
            best      = (sum_b > sum_d) ? sum_b : sum_d;
            res.flag  = 1'b1;
            res.score = (best > 255) ? 8'd255 : 8'(best);
        end
        return res;
    endfunction

    // noise background with bright and dark squares
    task automatic make_image();
        int amp;
        int sz;
        int sx;
        int sy;
        int level;
        amp = 1 + int'($urandom % ((THRESHOLD - 1) / 2));
        for (int y = 0; y < IMG_HEIGHT; y++) begin
            for (int x = 0; x < IMG_WIDTH; x++) begin
                img[y][x] = 8'(BASE + int'($urandom % (2 * amp + 1)) - amp);
            end
        end
        for (int n = 0; n < 4; n++) begin
            sz    = 5 + int'($urandom % 4);
            sx    = EDGE + int'($urandom % (IMG_WIDTH - 2 * EDGE - sz));
            sy    = EDGE + int'($urandom % (IMG_HEIGHT - 2 * EDGE - sz));
            level = (n % 2 == 0) ? BASE + 80 : BASE - 70;
            for (int y = sy; y < sy + sz; y++) begin
                for (int x = sx; x < sx + sz; x++) begin
                    img[y][x] = 8'(level + int'($urandom % (2 * amp + 1)) - amp);
                end
            end
        end
    endtask

    // one frame with random valid gaps, padding until the end pulse
    task automatic run_frame(input int num);
        int beat;
        int err_start;
        err_start  = err_cnt;
        make_image();
        point_idx  = 0;
        corner_cnt = 0;
        end_seen   = 1'b0;
        while (!o_ready) @(negedge i_clk);
        @(posedge i_clk);
        i_valid <= 1'b1;
        i_start <= 1'b1;
        i_pixel <= img[0][0];
        beat = 1;
        @(posedge i_clk);
        i_start <= 1'b0;
        while (!end_seen) begin
            if ($urandom % 4 != 0) begin
                i_valid <= 1'b1;
                i_pixel <= (beat < NPIX) ? img[beat / IMG_WIDTH][beat % IMG_WIDTH]
                                         : 8'($urandom);
                beat++;
            end else begin
                i_valid <= 1'b0;
                i_pixel <= 8'($urandom);
            end
            @(posedge i_clk);
        end
        i_valid <= 1'b0;
        check_field("point count", NPIX, point_idx);
        if (corner_cnt == 0) begin
            $display("frame %0d holds no corner inside the border", num);
            err_cnt++;
        end
        $display("test frame %0d: %0d points, %0d corners, %0d errors",
                 num, point_idx, corner_cnt, err_cnt - err_start);
    endtask

    // outputs are registered and settle well before the falling edge
    always @(negedge i_clk) begin
        corner_t exp_c;
        if (i_rst_n && o_point_valid) begin
            if (point_idx >= NPIX) begin
                $display("%0t point beyond the last pixel of the frame", $time);
                err_cnt++;
            end else begin
                exp_c = expected_corner(point_idx % IMG_WIDTH, point_idx / IMG_WIDTH);
                if (exp_c.flag) begin
                    corner_cnt++;
                end
                check_field("o_point.x", point_idx % IMG_WIDTH, int'(o_point.x));
                check_field("o_point.y", point_idx / IMG_WIDTH, int'(o_point.y));
                check_field("o_point.corner.flag", int'(exp_c.flag), int'(o_point.corner.flag));
                check_field("o_point.corner.score", int'(exp_c.score),
                            int'(o_point.corner.score));
                check_field("o_start", int'(point_idx == 0), int'(o_start));
                check_field("o_end", int'(point_idx == NPIX - 1), int'(o_end));
                check_field("o_ready", 0, int'(o_ready));
            end
            if (o_end) begin
                end_seen = 1'b1;
            end
            point_idx++;
        end else if (i_rst_n) begin
            check_field("o_start", 0, int'(o_start));
            check_field("o_end", 0, int'(o_end));
        end
    end

    a_point_needs_beat: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_point_valid |-> $past(i_valid))
        else begin
            $display("%0t point valid without a valid input beat", $time);
            err_cnt++;
        end

    a_start_at_origin: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_start |-> o_point_valid && (o_point.x == '0) && (o_point.y == '0))
        else begin
            $display("%0t start pulse not on the first point", $time);
            err_cnt++;
        end

    a_end_at_last: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_end |-> o_point_valid && (o_point.x == coord_t'(IMG_WIDTH - 1))
            && (o_point.y == coord_t'(IMG_HEIGHT - 1)))
        else begin
            $display("%0t end pulse not on the last point", $time);
            err_cnt++;
        end

    a_ready_after_end: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_end |=> o_ready)
        else begin
            $display("%0t ready did not return after the end of frame", $time);
            err_cnt++;
        end

    initial begin
        int err_start;
        err_cnt   = 0;
        check_cnt = 0;
        cycle_cnt = 0;
        end_seen  = 1'b0;
        point_idx = 0;
        i_rst_n   = 1'b0;
        i_valid   = 1'b0;
        i_start   = 1'b0;
        i_pixel   = '0;
        void'($urandom(31017));
        repeat (8) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        err_start = err_cnt;
        check_field("o_ready", 1, int'(o_ready));
        check_field("o_start", 0, int'(o_start));
        check_field("o_end", 0, int'(o_end));
        check_field("o_point_valid", 0, int'(o_point_valid));
        $display("test reset state: %0d errors", err_cnt - err_start);
        run_frame(1);
        // second frame right after the first
        run_frame(2);
        repeat (4) @(posedge i_clk);
        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fast_corner.f ====
src/fast_pkg.sv
src/fast_frame_ctrl.sv
src/fast_window.sv
src/fast_segment_test.sv
src/fast_border_mask.sv
src/fast_detector.sv
sim/tb_fast_detector.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fast_detector \
    -f fast_corner.f \
    -o sim_fast_corner

status=0
./obj_dir/sim_fast_corner > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "CHECKS FAILED" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
